// File: Makefile
# Verilator build and run for the TFT display subsystem

TOP    ?= tftDisplayTb
FLIST  ?= vlog.f
VFLAGS ?= --binary --timing --assert -j 0
OBJDIR ?= obj_dir
SIM    := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# pass or fail is taken from the printed result
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

// File: logic/displayPkg.sv
/* panel size, SPI timing, game state and mode codes, RGB565 colors,
   wire color codes and screen geometry */
package displayPkg;

    localparam int panelWidth  = 320;
    localparam int panelHeight = 240;
    localparam int xBits       = 9;
    localparam int yBits       = 8;

    localparam int bitsPerPixel   = 16;
    localparam int cyclesPerBit   = 2;
    localparam int cyclesPerPixel = bitsPerPixel * cyclesPerBit;

    localparam logic [1:0] stateMenu = 2'd0;
    localparam logic [1:0] statePlay = 2'd1;
    localparam logic [1:0] stateLost = 2'd2;
    localparam logic [1:0] stateWon  = 2'd3;

    localparam logic [1:0] modeMaze = 2'd0;
    localparam logic [1:0] modeWire = 2'd1; // codes 2 and 3 unused

    localparam logic [15:0] colorBlack  = 16'h0000;
    localparam logic [15:0] colorRed    = 16'hF800;
    localparam logic [15:0] colorWhite  = 16'hFFFF;
    localparam logic [15:0] colorYellow = 16'hFFE0;
    localparam logic [15:0] colorBlue   = 16'h001F;
    localparam logic [15:0] colorGray   = 16'hAD55;
    localparam logic [15:0] colorGreen  = 16'h07E0;
    localparam logic [15:0] colorCyan   = 16'h07FF;

    localparam logic [2:0] wireCodeRed    = 3'd0;
    localparam logic [2:0] wireCodeWhite  = 3'd1;
    localparam logic [2:0] wireCodeYellow = 3'd2;
    localparam logic [2:0] wireCodeBlue   = 3'd3;
    localparam logic [2:0] wireCodeGray   = 3'd4; // 5..7 draw black

    localparam int heartX0 = 8, heartPitch = 16, heartSize = 12, heartY0 = 4;
    localparam int playX0 = 120, playX1 = 199, playY0 = 90, playY1 = 149;
    localparam int borderThick = 4, borderY0 = 20;
    localparam int playerSize = 12;
    localparam int flagX0 = 296, flagX1 = 307, flagY0 = 212, flagY1 = 223;

    localparam int wireCount = 6, wireX0 = 40, wireX1 = 279;
    localparam int wireY0 = 40, wirePitch = 32, wireThick = 8;
    localparam int cutX0 = 150, cutX1 = 169;
    localparam int hiRows = 2; // highlight band above and below the wire

    localparam int bannerX0 = 100, bannerX1 = 219, bannerY0 = 100, bannerY1 = 139;

endpackage

// File: logic/pixelCompositor.sv
/* priority color selection by game state and play mode, wire color table */
`timescale 1ns/100ps

module pixelCompositor (
    input  logic [1:0]  gameState,
    input  logic [1:0]  playMode,
    input  logic [17:0] wireColors, // wire i in bits 3i+2..3i
    input  logic        heartPix,
    input  logic        playPix,
    input  logic        borderPix,
    input  logic        playerPix,
    input  logic        flagPix,
    input  logic [5:0]  wirePix,
    input  logic        wireHiPix,
    input  logic        bannerPix,
    output logic [15:0] pixelColor
);

    function automatic logic [15:0] wireColor(input logic [2:0] code);
        logic [15:0] c;
        case (code)
            displayPkg::wireCodeRed:    c = displayPkg::colorRed;
            displayPkg::wireCodeWhite:  c = displayPkg::colorWhite;
            displayPkg::wireCodeYellow: c = displayPkg::colorYellow;
            displayPkg::wireCodeBlue:   c = displayPkg::colorBlue;
            displayPkg::wireCodeGray:   c = displayPkg::colorGray;
            default:                    c = displayPkg::colorBlack;
        endcase
        return c;
    endfunction

    always_comb begin
        pixelColor = displayPkg::colorBlack;
        case (gameState)
            displayPkg::stateMenu: begin
                if (playPix) pixelColor = displayPkg::colorYellow;
            end
            displayPkg::statePlay: begin
                if (playMode == displayPkg::modeMaze) begin
                    if (heartPix)       pixelColor = displayPkg::colorRed;
                    else if (playerPix) pixelColor = displayPkg::colorWhite;
                    else if (flagPix)   pixelColor = displayPkg::colorGreen;
                    else if (borderPix) pixelColor = displayPkg::colorGray;
                end else if (playMode == displayPkg::modeWire) begin
                    if (heartPix) begin
                        pixelColor = displayPkg::colorRed;
                    end else if (wireHiPix) begin
                        pixelColor = displayPkg::colorCyan;
                    end else begin
                        // later wires win, so scan upward
                        for (int i = 0; i < displayPkg::wireCount; i++) begin
                            if (wirePix[i]) pixelColor = wireColor(wireColors[3*i +: 3]);
                        end
                    end
                end else begin
                    pixelColor = displayPkg::colorCyan; // unused mode
                end
            end
            displayPkg::stateWon: begin
                if (bannerPix) pixelColor = displayPkg::colorGreen;
            end
            default: begin  // lost
                if (bannerPix) pixelColor = displayPkg::colorRed;
            end
        endcase
    end

endmodule

// File: logic/pixelScanner.sv
/* column-major pixel scanner, y fastest then x, stepped by the load strobe */
`timescale 1ns/100ps

module pixelScanner (
    input  logic                         fbClk,
    input  logic                         rstN,
    input  logic                         pixelLoad, // advance to next pixel
    output logic [displayPkg::xBits-1:0] x,
    output logic [displayPkg::yBits-1:0] y
);

    logic yLast;
    logic xLast;

    assign yLast = (y == displayPkg::panelHeight - 1);
    assign xLast = (x == displayPkg::panelWidth - 1);

    // y runs down the column, then x moves one column right
    always_ff @(posedge fbClk) begin
        if (!rstN) begin
            x <= '0;
            y <= '0;
        end else if (pixelLoad) begin
            if (yLast) begin
                y <= '0;
                if (xLast) begin
                    x <= '0;        // end of frame
                end else begin
                    x <= x + 1'b1;
                end
            end else begin
                y <= y + 1'b1;
            end
        end
    end

endmodule

// File: logic/sceneShapes.sv
/* per-pixel shape flags: hearts, play button, maze border, player, flag,
   wires with cut gaps, wire highlight and the end-of-game banner */
`timescale 1ns/100ps

module sceneShapes (
    input  logic [displayPkg::xBits-1:0] x,
    input  logic [displayPkg::yBits-1:0] y,
    input  logic [1:0]                   lives,
    input  logic [displayPkg::xBits-1:0] playerX,
    input  logic [displayPkg::yBits-1:0] playerY,
    input  logic [5:0]                   wireCut,
    input  logic [2:0]                   wireSel,
    output logic                         heartPix,
    output logic                         playPix,
    output logic                         borderPix,
    output logic                         playerPix,
    output logic                         flagPix,
    output logic [5:0]                   wirePix,
    output logic                         wireHiPix,
    output logic                         bannerPix
);

    // fixed rectangles and the border
    always_comb begin
        int cx;
        int cy;
        cx = int'(x);
        cy = int'(y);

        playPix = (cx >= displayPkg::playX0) && (cx <= displayPkg::playX1) &&
                  (cy >= displayPkg::playY0) && (cy <= displayPkg::playY1);

        flagPix = (cx >= displayPkg::flagX0) && (cx <= displayPkg::flagX1) &&
                  (cy >= displayPkg::flagY0) && (cy <= displayPkg::flagY1);

        bannerPix = (cx >= displayPkg::bannerX0) && (cx <= displayPkg::bannerX1) &&
                    (cy >= displayPkg::bannerY0) && (cy <= displayPkg::bannerY1);

        borderPix = (cx < displayPkg::borderThick) ||
                    (cx >= displayPkg::panelWidth - displayPkg::borderThick) ||
                    ((cy >= displayPkg::borderY0) &&
                     (cy < displayPkg::borderY0 + displayPkg::borderThick)) ||
                    (cy >= displayPkg::panelHeight - displayPkg::borderThick);
    end

    // hearts and the player square
    always_comb begin
        int cx;
        int cy;
        int hx;
        int px;
        int py;
        cx = int'(x);
        cy = int'(y);
        px = int'(playerX);
        py = int'(playerY);

        heartPix = 1'b0;
        for (int i = 0; i < 3; i++) begin
            hx = displayPkg::heartX0 + displayPkg::heartPitch * i;
            if ((i < int'(lives)) && (cx >= hx) && (cx < hx + displayPkg::heartSize) &&
                (cy >= displayPkg::heartY0) &&
                (cy < displayPkg::heartY0 + displayPkg::heartSize)) begin
                heartPix = 1'b1;
            end
        end

        playerPix = (cx >= px) && (cx < px + displayPkg::playerSize) &&
                    (cy >= py) && (cy < py + displayPkg::playerSize);
    end

    // horizontal wires, gap where cut, band around the selected one
    always_comb begin
        int cx;
        int cy;
        int top;
        int bot;
        logic inSpan;
        logic inGap;
        cx = int'(x);
        cy = int'(y);
        inSpan = (cx >= displayPkg::wireX0) && (cx <= displayPkg::wireX1);
        inGap  = (cx >= displayPkg::cutX0) && (cx <= displayPkg::cutX1);

        wirePix   = '0;
        wireHiPix = 1'b0;
        for (int i = 0; i < displayPkg::wireCount; i++) begin
            top = displayPkg::wireY0 + displayPkg::wirePitch * i;
            bot = top + displayPkg::wireThick - 1;
            wirePix[i] = inSpan && (cy >= top) && (cy <= bot) && !(wireCut[i] && inGap);
            if ((int'(wireSel) == i) && inSpan &&
                (((cy >= top - displayPkg::hiRows) && (cy < top)) ||
                 ((cy > bot) && (cy <= bot + displayPkg::hiRows)))) begin
                wireHiPix = 1'b1;   // sel 6,7 never matches
            end
        end
    end

endmodule

// File: logic/spiPixelSerializer.sv
/* SPI serializer, 16-bit color MSB first at two cycles per bit,
   one load strobe per 32 cycles */
`timescale 1ns/100ps

module spiPixelSerializer (
    input  logic                                fbClk,
    input  logic                                rstN,
    input  logic [displayPkg::bitsPerPixel-1:0] pixelColor,
    output logic                                pixelLoad,
    output logic                                tftSck,
    output logic                                tftSdi,
    output logic                                tftCs
);

    logic [displayPkg::bitsPerPixel-1:0] shiftReg;
    logic [4:0]                          phase;     // cycle within pixel
    logic                                started;   // first load done
    logic                                bitEnd;    // second half of a bit

    assign bitEnd = (phase % displayPkg::cyclesPerBit) == displayPkg::cyclesPerBit - 1;

    // before the first word, load as soon as reset is released
    assign pixelLoad = started ? (phase == displayPkg::cyclesPerPixel - 1) : rstN;

    always_ff @(posedge fbClk) begin
        if (!rstN) begin
            phase   <= '0;
            started <= 1'b0;
        end else if (pixelLoad) begin
            phase   <= '0;
            started <= 1'b1;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // shifts after the high half of each bit
    always_ff @(posedge fbClk) begin
        if (pixelLoad) begin
            shiftReg <= pixelColor;
        end else if (bitEnd) begin
            shiftReg <= {shiftReg[displayPkg::bitsPerPixel-2:0], 1'b0};
        end
    end

    assign tftCs  = !started;                  // low for good after first load
    assign tftSck = started & bitEnd;          // panel samples on rise
    assign tftSdi = started & shiftReg[displayPkg::bitsPerPixel-1];

endmodule

// File: logic/tftDisplay.sv
/* top level: scanner, shape flags, compositor and SPI serializer */
`timescale 1ns/100ps

module tftDisplay (
    input  logic                         fbClk,
    input  logic                         rstN,
    input  logic [1:0]                   gameState,
    input  logic [1:0]                   playMode,
    input  logic [1:0]                   lives,
    input  logic [displayPkg::xBits-1:0] playerX,
    input  logic [displayPkg::yBits-1:0] playerY,
    input  logic [17:0]                  wireColors,
    input  logic [5:0]                   wireCut,
    input  logic [2:0]                   wireSel,
    output logic [displayPkg::xBits-1:0] x,
    output logic [displayPkg::yBits-1:0] y,
    output logic                         tftSck,
    output logic                         tftSdi,
    output logic                         tftCs
);

    logic        pixelLoad;
    logic [15:0] pixelColor;
    logic        heartPix, playPix, borderPix, playerPix, flagPix, bannerPix;
    logic [5:0]  wirePix;
    logic        wireHiPix;

    pixelScanner scanner (
        .fbClk(fbClk), .rstN(rstN), .pixelLoad(pixelLoad), .x(x), .y(y)
    );

    sceneShapes shapes (
        .x(x), .y(y), .lives(lives), .playerX(playerX), .playerY(playerY),
        .wireCut(wireCut), .wireSel(wireSel),
        .heartPix(heartPix), .playPix(playPix), .borderPix(borderPix),
        .playerPix(playerPix), .flagPix(flagPix), .wirePix(wirePix),
        .wireHiPix(wireHiPix), .bannerPix(bannerPix)
    );

    pixelCompositor compositor (
        .gameState(gameState), .playMode(playMode), .wireColors(wireColors),
        .heartPix(heartPix), .playPix(playPix), .borderPix(borderPix),
        .playerPix(playerPix), .flagPix(flagPix), .wirePix(wirePix),
        .wireHiPix(wireHiPix), .bannerPix(bannerPix), .pixelColor(pixelColor)
    );

    // color is captured on the same edge the scanner steps
    spiPixelSerializer serializer (
        .fbClk(fbClk), .rstN(rstN), .pixelColor(pixelColor), .pixelLoad(pixelLoad),
        .tftSck(tftSck), .tftSdi(tftSdi), .tftCs(tftCs)
    );

endmodule

// File: test/spiLink_chk.sv
/* SPI link assertions, bound into the serializer */
`timescale 1ns/100ps

module spiLink_chk (
    input logic fbClk,
    input logic rstN,
    input logic tftSck,
    input logic tftSdi,
    input logic tftCs
);

    int failCount = 0;  // failed assertions

    // panel samples on the rise, so data holds through the high half
    sdiStable: assert property (@(posedge fbClk) disable iff (!rstN)
        tftSck |-> $stable(tftSdi))
        else begin
            $error("tftSdi changed while tftSck was high");
            failCount++;
        end

    sckToggles: assert property (@(posedge fbClk) disable iff (!rstN)
        (!tftCs && !$past(tftCs)) |-> (tftSck != $past(tftSck)))
        else begin
            $error("tftSck missed a toggle while tftCs was low");
            failCount++;
        end

    csHeldLow: assert property (@(posedge fbClk) disable iff (!rstN)
        !tftCs |=> !tftCs)
        else begin
            $error("tftCs rose after it had fallen");
            failCount++;
        end

endmodule

// File: test/tftDisplayMon.sv
/* checker: reference color model, scan order check and SPI word capture */
`timescale 1ns/100ps

module tftDisplayMon (
    input  logic                         fbClk,
    input  logic                         rstN,
    input  logic [displayPkg::xBits-1:0] x,
    input  logic [displayPkg::yBits-1:0] y,
    input  logic [1:0]                   gameState,
    input  logic [1:0]                   playMode,
    input  logic [1:0]                   lives,
    input  logic [displayPkg::xBits-1:0] playerX,
    input  logic [displayPkg::yBits-1:0] playerY,
    input  logic [17:0]                  wireColors,
    input  logic [5:0]                   wireCut,
    input  logic [2:0]                   wireSel,
    input  logic                         tftSck,
    input  logic                         tftSdi,
    input  logic                         tftCs,
    output int                           errCount,
    output int                           wordCount
);

    logic [15:0] expQ[$];
    int          expX[$];
    int          expY[$];
    logic [15:0] word;
    logic [15:0] expColor;
    int          phaseCnt;
    int          loadsSeen;
    int          bitCnt;
    int          nextX;
    int          nextY;
    int          ex;
    int          ey;

    function automatic logic [15:0] codeColor(input logic [2:0] code);
        case (code)
            3'd0:    return displayPkg::colorRed;
            3'd1:    return displayPkg::colorWhite;
            3'd2:    return displayPkg::colorYellow;
            3'd3:    return displayPkg::colorBlue;
            3'd4:    return displayPkg::colorGray;
            default: return displayPkg::colorBlack;  // codes 5..7
        endcase
    endfunction

    function automatic logic [15:0] modelColor(input int px, input int py, input int lv,
                                               input int plX, input int plY, input int sel);
        logic heart;
        logic button;
        logic border;
        logic player;
        logic flag;
        logic banner;
        logic hiBand;
        logic inSpan;
        int   hx;
        int   top;
        int   wireHit;
        hx = px - displayPkg::heartX0;
        heart = (hx >= 0) && (hx / displayPkg::heartPitch < lv) &&
                (hx % displayPkg::heartPitch < displayPkg::heartSize) &&
                (py >= displayPkg::heartY0) && (py < displayPkg::heartY0 + 12);
        button = (px >= 120) && (px <= 199) && (py >= 90) && (py <= 149);
        border = (px <= 3) || (px >= 316) || ((py >= 20) && (py <= 23)) || (py >= 236);
        player = (px >= plX) && (px <= plX + 11) && (py >= plY) && (py <= plY + 11);
        flag   = (px >= 296) && (px <= 307) && (py >= 212) && (py <= 223);
        banner = (px >= 100) && (px <= 219) && (py >= 100) && (py <= 139);
        inSpan = (px >= 40) && (px <= 279);
        wireHit = -1;
        hiBand  = 1'b0;
        for (int i = 0; i < displayPkg::wireCount; i++) begin
            top = 40 + 32 * i;
            if (inSpan && (py >= top) && (py <= top + 7) &&
                !(wireCut[i] && (px >= 150) && (px <= 169))) begin
                wireHit = i;  // last one wins
            end
            if (inSpan && (i == sel) &&
                (((py >= top - 2) && (py <= top - 1)) || ((py >= top + 8) && (py <= top + 9)))) begin
                hiBand = 1'b1;
            end
        end
        if (gameState == displayPkg::stateMenu) begin
            return button ? displayPkg::colorYellow : displayPkg::colorBlack;
        end else if (gameState == displayPkg::stateWon) begin
            return banner ? displayPkg::colorGreen : displayPkg::colorBlack;
        end else if (gameState == displayPkg::stateLost) begin
            return banner ? displayPkg::colorRed : displayPkg::colorBlack;
        end else if (playMode == displayPkg::modeMaze) begin
            if (heart) return displayPkg::colorRed;
            if (player) return displayPkg::colorWhite;
            if (flag) return displayPkg::colorGreen;
            if (border) return displayPkg::colorGray;
            return displayPkg::colorBlack;
        end else if (playMode == displayPkg::modeWire) begin
            if (heart) return displayPkg::colorRed;
            if (hiBand) return displayPkg::colorCyan;
            if (wireHit >= 0) return codeColor(wireColors[3*wireHit +: 3]);
            return displayPkg::colorBlack;
        end
        return displayPkg::colorCyan;  // modes 2 and 3
    endfunction

    initial begin
        errCount  = 0;
        wordCount = 0;
    end

    // everything sampled mid-cycle, the next rising edge is a load when phaseCnt is 0
    always @(negedge fbClk) begin
        if (!rstN) begin
            phaseCnt  = 0;
            loadsSeen = 0;
            bitCnt    = 0;
            nextX     = 0;
            nextY     = 0;
            if (tftCs !== 1'b1 || tftSck !== 1'b0 || tftSdi !== 1'b0 || x !== '0 || y !== '0) begin
                errCount++;
                $display("[ERROR] %0t: outputs not at reset values during reset", $time);
            end
        end else begin
            if (tftSck === 1'b1) begin
                word = {word[14:0], tftSdi};
                bitCnt++;
                if (bitCnt == displayPkg::bitsPerPixel) begin
                    bitCnt = 0;
                    if (expQ.size() == 0) begin
                        errCount++;
                        $display("[ERROR] %0t: serial word %h with no pixel loaded", $time, word);
                    end else begin
                        expColor = expQ.pop_front();
                        ex = expX.pop_front();
                        ey = expY.pop_front();
                        wordCount++;
                        if (word !== expColor) begin
                            errCount++;
                            $display("[ERROR] %0t: pixel (%0d,%0d) sent %h, expected %h",
                                     $time, ex, ey, word, expColor);
                        end
                    end
                end
            end
            if ((loadsSeen == 0 && tftCs !== 1'b1) || (loadsSeen > 0 && tftCs !== 1'b0)) begin
                errCount++;
                $display("[ERROR] %0t: tftCs is %b after %0d loads", $time, tftCs, loadsSeen);
            end
            if (int'(x) != nextX || int'(y) != nextY) begin
                errCount++;
                $display("[ERROR] %0t: scanner at (%0d,%0d), expected (%0d,%0d)",
                         $time, x, y, nextX, nextY);
            end
            if (phaseCnt == 0) begin
                expQ.push_back(modelColor(int'(x), int'(y), int'(lives), int'(playerX),
                                          int'(playerY), int'(wireSel)));
                expX.push_back(int'(x));
                expY.push_back(int'(y));
                loadsSeen++;
                if (nextY == displayPkg::panelHeight - 1) begin
                    nextY = 0;
                    nextX = (nextX + 1) % displayPkg::panelWidth;
                end else begin
                    nextY++;
                end
            end
            phaseCnt = (phaseCnt + 1) % displayPkg::cyclesPerPixel;
        end
    end

endmodule

// File: test/tftDisplayTb.sv
/* testbench top: clock, reset, seeded random scenes, timeout and final report */
`timescale 1ns/100ps

module tftDisplayTb;

    localparam int sceneCount     = 12;
    localparam int pixelsPerScene = 256;
    localparam int resetCycles    = 3;
    localparam int driveDelay     = 10;
    localparam int timeoutCycles  =
        (sceneCount * pixelsPerScene + 8) * displayPkg::cyclesPerPixel + resetCycles;

    logic                         fbClk = 1'b0;
    logic                         rstN;
    logic [1:0]                   gameState;
    logic [1:0]                   playMode;
    logic [1:0]                   lives;
    logic [displayPkg::xBits-1:0] playerX;
    logic [displayPkg::yBits-1:0] playerY;
    logic [17:0]                  wireColors;
    logic [5:0]                   wireCut;
    logic [2:0]                   wireSel;
    logic [displayPkg::xBits-1:0] x;
    logic [displayPkg::yBits-1:0] y;
    logic                         tftSck;
    logic                         tftSdi;
    logic                         tftCs;
    int                           monErrors;
    int                           monWords;
    int                           errors;
    int                           cycles = 0;

    initial begin
        forever #50 fbClk = ~fbClk;
    end

    tftDisplay dut (
        .fbClk(fbClk), .rstN(rstN), .gameState(gameState), .playMode(playMode),
        .lives(lives), .playerX(playerX), .playerY(playerY), .wireColors(wireColors),
        .wireCut(wireCut), .wireSel(wireSel), .x(x), .y(y),
        .tftSck(tftSck), .tftSdi(tftSdi), .tftCs(tftCs)
    );

    tftDisplayMon mon (
        .fbClk(fbClk), .rstN(rstN), .x(x), .y(y), .gameState(gameState),
        .playMode(playMode), .lives(lives), .playerX(playerX), .playerY(playerY),
        .wireColors(wireColors), .wireCut(wireCut), .wireSel(wireSel),
        .tftSck(tftSck), .tftSdi(tftSdi), .tftCs(tftCs),
        .errCount(monErrors), .wordCount(monWords)
    );

    bind spiPixelSerializer spiLink_chk linkChk (
        .fbClk(fbClk), .rstN(rstN), .tftSck(tftSck), .tftSdi(tftSdi), .tftCs(tftCs)
    );

    // one pixel is a fixed 32 cycles, no back-pressure from the panel
    task automatic waitLoads(input int n);
        repeat (n * displayPkg::cyclesPerPixel) @(posedge fbClk);
        #driveDelay;
    endtask

    task automatic driveScene(input int s);
        lives      = 2'($urandom);
        wireColors = 18'($urandom);
        wireCut    = 6'($urandom);
        wireSel    = 3'($urandom);
        playMode   = 2'($urandom);
        playerX    = 9'($urandom_range(displayPkg::panelWidth - 1, 0));
        playerY    = 8'($urandom_range(displayPkg::panelHeight - 1, 0));
        if (s % 2 == 1) begin
            playerX = 9'($urandom_range(16, 0));  // over left border and hearts
        end
        if (s % 3 == 0) begin
            playerY = 8'($urandom_range(28, 0));  // across the top rows
        end
        case (s % 6)
            0: gameState = displayPkg::stateMenu;
            1: begin
                gameState = displayPkg::statePlay;
                playMode  = displayPkg::modeMaze;
            end
            2: begin
                gameState = displayPkg::statePlay;
                playMode  = displayPkg::modeWire;
            end
            3: gameState = displayPkg::stateWon;
            4: gameState = displayPkg::stateLost;
            default: begin
                gameState = displayPkg::statePlay;
                playMode  = 2'(2 + $urandom_range(1, 0));  // unused modes
            end
        endcase
    endtask

    always @(posedge fbClk) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("timeout: run did not end within %0d cycles", timeoutCycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hd9d0));
        rstN = 1'b0;
        driveScene(0);
        repeat (resetCycles) @(posedge fbClk);
        #driveDelay;
        rstN = 1'b1;
        @(posedge fbClk);  // first load edge
        #driveDelay;
        waitLoads(pixelsPerScene - 1);
        for (int s = 1; s < sceneCount; s++) begin
            driveScene(s);
            waitLoads(pixelsPerScene);
        end
        waitLoads(1);  // last word drains
        errors = monErrors + dut.serializer.linkChk.failCount;
        if (monWords != sceneCount * pixelsPerScene) begin
            $display("only %0d serial words were checked, expected %0d",
                     monWords, sceneCount * pixelsPerScene);
            errors++;
        end
        $display("errors: %0d (monitor %0d, assertions %0d), words checked: %0d",
                 errors, monErrors, dut.serializer.linkChk.failCount, monWords);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
logic/displayPkg.sv
logic/pixelScanner.sv
logic/sceneShapes.sv
logic/pixelCompositor.sv
logic/spiPixelSerializer.sv
logic/tftDisplay.sv
test/spiLink_chk.sv
test/tftDisplayMon.sv
test/tftDisplayTb.sv
